// ==== rtl/hilo_file.sv ====
`timescale 1ns/1ps

module hilo_file (
    input  logic                   clk,
    input  logic                   rst_n,
    input  muldiv_pkg::md_result_t result,
    output muldiv_pkg::md_word_t   hi,
    output muldiv_pkg::md_word_t   lo,
    output logic                   done
);
    import muldiv_pkg::*;

    logic [2*md_xlen-1:0] hilo_q;
    logic [2*md_xlen-1:0] hilo_d;
    logic                 done_q;

    // accumulation wraps modulo 2^64.
    always_comb begin
        hilo_d = hilo_q;
        if (result.valid) begin
            case (result.op)
                OP_MULT, OP_DIV: hilo_d = result.value;
                OP_MADD:         hilo_d = hilo_q + result.value;
                OP_MSUB:         hilo_d = hilo_q - result.value;
                default:         hilo_d = hilo_q;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hilo_q <= '0;
            done_q <= 1'b0;
        end else begin
            hilo_q <= hilo_d;
            done_q <= result.valid; // pulses with the hi/lo update.
        end
    end

    assign hi   = hilo_q[2*md_xlen-1:md_xlen];
    assign lo   = hilo_q[md_xlen-1:0];
    assign done = done_q;

endmodule

// ==== rtl/muldiv_core.sv ====
`timescale 1ns/1ps

module muldiv_core (
    input  logic                   clk,
    input  logic                   rst_n,
    input  muldiv_pkg::md_prep_t   prep,
    output muldiv_pkg::md_result_t result,
    output logic                   busy
);
    import muldiv_pkg::*;

    logic                 is_mul;
    logic                 div_start;
    logic                 div_finish;
    md_word_t             div_quo;
    md_word_t             div_rem;
    md_word_t             quo_signed;
    md_word_t             rem_signed;
    logic [2*md_xlen-1:0] mag_product;
    logic [2*md_xlen-1:0] signed_product;
    logic                 neg_quo_q;
    logic                 neg_rem_q;
    logic                 busy_q;

    // ======================================================================
    // multiply path
    // ======================================================================

    always_comb begin
        case (prep.op)
            OP_MULT, OP_MADD, OP_MSUB: is_mul = 1'b1;
            default:                   is_mul = 1'b0;
        endcase
    end

    assign mag_product    = (2*md_xlen)'(prep.mag_a) * (2*md_xlen)'(prep.mag_b);
    assign signed_product = prep.neg_product ? -mag_product : mag_product;

    // ======================================================================
    // divide path
    // ======================================================================

    assign div_start = prep.valid && (prep.op == OP_DIV);

    radix2_divider u_divider (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (div_start),
        .dividend  (prep.mag_a),
        .divisor   (prep.mag_b),
        .quotient  (div_quo),
        .remainder (div_rem),
        .finish    (div_finish)
    );

    // signs wait here while the divider runs.
    always_ff @(posedge clk) begin
        if (div_start) begin
            neg_quo_q <= prep.neg_product;
            neg_rem_q <= prep.neg_remainder;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q <= 1'b0;
        end else if (div_start) begin
            busy_q <= 1'b1;
        end else if (div_finish) begin
            busy_q <= 1'b0;
        end
    end

    assign quo_signed = neg_quo_q ? -div_quo : div_quo;
    assign rem_signed = neg_rem_q ? -div_rem : div_rem;

    always_comb begin
        result = '{op: OP_NONE, value: signed_product, valid: 1'b0};
        if (div_finish) begin
            result = '{op: OP_DIV, value: {rem_signed, quo_signed}, valid: 1'b1};
        end else if (prep.valid && is_mul) begin
            result = '{op: prep.op, value: signed_product, valid: 1'b1};
        end
    end

    assign busy = busy_q;

endmodule

// ==== rtl/muldiv_issue.sv ====
`timescale 1ns/1ps

module muldiv_issue (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 issue,
    input  muldiv_pkg::md_req_t  req,
    input  logic                 busy,
    output muldiv_pkg::md_prep_t prep
);
    import muldiv_pkg::*;

    logic     accept;
    logic     div_pending;
    logic     sign_a;
    logic     sign_b;
    md_word_t mag_a_d;
    md_word_t mag_b_d;

    logic     valid_q;
    md_op_e   op_q;
    md_word_t mag_a_q;
    md_word_t mag_b_q;
    logic     neg_product_q;
    logic     neg_remainder_q;

    // a div still sitting here has not reached the divider yet.
    assign div_pending = valid_q && (op_q == OP_DIV);
    assign accept      = issue && !busy && !(div_pending && (req.op == OP_DIV));

    assign sign_a  = !req.is_unsigned && req.operand_a[md_xlen-1];
    assign sign_b  = !req.is_unsigned && req.operand_b[md_xlen-1];
    assign mag_a_d = sign_a ? -req.operand_a : req.operand_a;
    assign mag_b_d = sign_b ? -req.operand_b : req.operand_b;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= accept; // one cycle per request.
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            op_q            <= req.op;
            mag_a_q         <= mag_a_d;
            mag_b_q         <= mag_b_d;
            neg_product_q   <= sign_a ^ sign_b;
            neg_remainder_q <= sign_a;
        end
    end

    assign prep = '{op:            op_q,
                    mag_a:         mag_a_q,
                    mag_b:         mag_b_q,
                    neg_product:   neg_product_q,
                    neg_remainder: neg_remainder_q,
                    valid:         valid_q};

endmodule

// ==== rtl/muldiv_pkg.sv ====
package muldiv_pkg;

    // ======================================================================
    // widths
    // ======================================================================

    localparam int md_xlen = 32; // operand width, fixed by the isa.

    typedef logic [md_xlen-1:0] md_word_t;

    // ======================================================================
    // encodings
    // ======================================================================

    typedef enum logic [2:0] {
        OP_NONE = 3'd0,
        OP_MULT = 3'd1,
        OP_MADD = 3'd2,
        OP_MSUB = 3'd3,
        OP_DIV  = 3'd4
    } md_op_e;

    // restoring divider sequencing.
    typedef enum logic [1:0] {
        DIV_IDLE = 2'd0,
        DIV_RUN  = 2'd1,
        DIV_DONE = 2'd2
    } div_state_e;

    // ======================================================================
    // stage bundles
    // ======================================================================

    typedef struct packed {
        md_op_e   op;
        logic     is_unsigned;
        md_word_t operand_a;
        md_word_t operand_b;
    } md_req_t;

    // operands as magnitudes, signs already resolved.
    typedef struct packed {
        md_op_e   op;
        md_word_t mag_a;
        md_word_t mag_b;
        logic     neg_product;   // also the quotient sign.
        logic     neg_remainder; // dividend sign.
        logic     valid;
    } md_prep_t;

    typedef struct packed {
        md_op_e                 op;
        logic [2*md_xlen-1:0]   value; // upper word goes to hi.
        logic                   valid;
    } md_result_t;

endpackage

// ==== rtl/muldiv_unit.sv ====
`timescale 1ns/1ps

module muldiv_unit (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 issue,
    input  muldiv_pkg::md_req_t  req,
    output logic                 busy,
    output logic                 done,
    output muldiv_pkg::md_word_t hi,
    output muldiv_pkg::md_word_t lo
);
    import muldiv_pkg::*;

    md_prep_t   prep;
    md_result_t result;

    // request capture and sign handling.
    muldiv_issue u_issue (
        .clk   (clk),
        .rst_n (rst_n),
        .issue (issue),
        .req   (req),
        .busy  (busy),
        .prep  (prep)
    );

    muldiv_core u_core (
        .clk    (clk),
        .rst_n  (rst_n),
        .prep   (prep),
        .result (result),
        .busy   (busy)
    );

    // architectural hi/lo.
    hilo_file u_hilo (
        .clk    (clk),
        .rst_n  (rst_n),
        .result (result),
        .hi     (hi),
        .lo     (lo),
        .done   (done)
    );

endmodule

// ==== rtl/radix2_divider.sv ====
`timescale 1ns/1ps

module radix2_divider (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 start,
    input  muldiv_pkg::md_word_t dividend,
    input  muldiv_pkg::md_word_t divisor,
    output muldiv_pkg::md_word_t quotient,
    output muldiv_pkg::md_word_t remainder,
    output logic                 finish
);
    import muldiv_pkg::*;

    localparam int cnt_w = $clog2(md_xlen);

    div_state_e       state_q;
    logic [cnt_w-1:0] count_q;
    md_word_t         rem_q;
    md_word_t         quo_q;
    md_word_t         dvs_q;
    logic [md_xlen:0] partial;
    logic [md_xlen:0] diff;

    // bring down the next dividend bit, then trial subtract.
    assign partial = {rem_q, quo_q[md_xlen-1]};
    assign diff    = partial - {1'b0, dvs_q};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= DIV_IDLE;
            count_q <= '0;
        end else begin
            case (state_q)
                DIV_IDLE: begin
                    if (start) begin
                        state_q <= DIV_RUN;
                        count_q <= '0;
                    end
                end
                DIV_RUN: begin
                    count_q <= count_q + 1'b1;
                    if (count_q == cnt_w'(md_xlen - 1)) begin
                        state_q <= DIV_DONE;
                    end
                end
                default: state_q <= DIV_IDLE; // done lasts one cycle.
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state_q == DIV_IDLE) && start) begin
            rem_q <= '0;
            quo_q <= dividend; // quotient bits shift in behind it.
            dvs_q <= divisor;
        end else if (state_q == DIV_RUN) begin
            if (!diff[md_xlen]) begin
                rem_q <= diff[md_xlen-1:0];
                quo_q <= {quo_q[md_xlen-2:0], 1'b1};
            end else begin
                rem_q <= partial[md_xlen-1:0]; // restore.
                quo_q <= {quo_q[md_xlen-2:0], 1'b0};
            end
        end
    end

    assign quotient  = quo_q;
    assign remainder = rem_q;
    assign finish    = (state_q == DIV_DONE);

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the muldiv unit testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module muldiv_unit_tb -f vlog.f -o muldiv_sim

output="$(./obj_dir/muldiv_sim)"
echo "$output"

if grep -qF "All tests passed!" <<< "$output"; then
    exit 0
else
    exit 1
fi

// ==== verification/muldiv_unit_tb.sv ====
`timescale 1ns/1ps

module muldiv_unit_tb;
    import muldiv_pkg::*;

    localparam int mul_latency = 2;           // edges to done including the accepting one.
    localparam int div_latency = md_xlen + 3;
    localparam int cycle_limit = 6000;

    logic       clk = 1'b0;
    logic       rst_n;
    logic       issue;
    md_req_t    req;
    logic       busy;
    logic       done;
    md_word_t   hi;
    md_word_t   lo;

    logic [2*md_xlen-1:0] model_hilo;
    int                   mismatch_count = 0;
    int                   missing_count = 0;
    int unsigned          cycle_count = 0;

    muldiv_unit uut (
        .clk   (clk),
        .rst_n (rst_n),
        .issue (issue),
        .req   (req),
        .busy  (busy),
        .done  (done),
        .hi    (hi),
        .lo    (lo)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout: the run went past %0d cycles without finishing", cycle_limit);
            $display("Test failures found");
            $finish;
        end
    end

    // ======================================================================
    // compare tasks
    // ======================================================================

    task automatic check_word(input string name, input md_word_t expected, input md_word_t actual);
        if (actual !== expected) begin
            $display("FAILED at %0t: %s expected %h, actual %h", $time, name, expected, actual);
            mismatch_count++;
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("FAILED at %0t: %s expected %b, actual %b", $time, name, expected, actual);
            mismatch_count++;
        end
    endtask

    task automatic check_count(input string name, input int expected, input int actual);
        if (actual != expected) begin
            $display("FAILED at %0t: %s expected %0d, actual %0d", $time, name, expected, actual);
            mismatch_count++;
        end
    endtask

    // ======================================================================
    // reference model
    // ======================================================================

    function automatic logic [2*md_xlen-1:0] model_product(input logic uns, input md_word_t a,
                                                           input md_word_t b);
        longint sa;
        longint sb;
        logic [2*md_xlen-1:0] ua;
        logic [2*md_xlen-1:0] ub;
        sa = $signed(a);
        sb = $signed(b);
        ua = {{md_xlen{1'b0}}, a};
        ub = {{md_xlen{1'b0}}, b};
        if (uns) begin
            return ua * ub;
        end
        return sa * sb;
    endfunction

    // remainder in the upper word, quotient in the lower.
    function automatic logic [2*md_xlen-1:0] model_division(input logic uns, input md_word_t a,
                                                            input md_word_t b);
        longint   sa;
        longint   sb;
        longint   q;
        longint   r;
        md_word_t uq;
        sa = $signed(a);
        sb = $signed(b);
        if (b == '0) begin
            uq = (!uns && a[md_xlen-1]) ? md_word_t'(1) : '1; // negated all-ones.
            return {a, uq};
        end
        if (uns) begin
            return {a % b, a / b};
        end
        q = sa / sb;
        r = sa % sb;
        return {r[md_xlen-1:0], q[md_xlen-1:0]};
    endfunction

    task automatic model_apply(input md_op_e code, input logic uns, input md_word_t a,
                               input md_word_t b);
        case (code)
            OP_MULT: model_hilo = model_product(uns, a, b);
            OP_MADD: model_hilo = model_hilo + model_product(uns, a, b);
            OP_MSUB: model_hilo = model_hilo - model_product(uns, a, b);
            OP_DIV:  model_hilo = model_division(uns, a, b);
            default: model_hilo = model_hilo;
        endcase
    endtask

    // ======================================================================
    // stimulus helpers
    // ======================================================================

    task automatic drive_request(input md_op_e code, input logic uns, input md_word_t a,
                                 input md_word_t b);
        issue = 1'b1;
        req   = '{op: code, is_unsigned: uns, operand_a: a, operand_b: b};
    endtask

    task automatic idle_inputs();
        issue = 1'b0;
        req   = '0;
    endtask

    // elapsed counts edges since the accepting one.
    task automatic wait_done(input int latency, input int elapsed);
        while (!done && elapsed < latency + 4) begin
            @(negedge clk);
            elapsed++;
        end
        if (!done) begin
            $display("Error at %0t: done never arrived after the request", $time);
            missing_count++;
        end else begin
            check_count("done_latency", latency, elapsed);
        end
    endtask

    task automatic check_result();
        check_word("hi", model_hilo[2*md_xlen-1:md_xlen], hi);
        check_word("lo", model_hilo[md_xlen-1:0], lo);
        @(negedge clk);
        check_flag("done", 1'b0, done); // one-cycle pulse.
    endtask

    task automatic run_single(input md_op_e code, input logic uns, input md_word_t a,
                              input md_word_t b);
        @(negedge clk);
        drive_request(code, uns, a, b);
        @(posedge clk);
        model_apply(code, uns, a, b);
        @(negedge clk);
        idle_inputs();
        wait_done((code == OP_DIV) ? div_latency : mul_latency, 1);
        check_result();
    endtask

    // ======================================================================
    // tests
    // ======================================================================

    task automatic test_mult_corners();
        md_word_t corners [5] = '{32'h0, 32'h1, 32'hffff_ffff, 32'h8000_0000, 32'h7fff_ffff};
        for (int u = 0; u < 2; u++) begin
            foreach (corners[i]) begin
                foreach (corners[j]) begin
                    run_single(OP_MULT, u[0], corners[i], corners[j]);
                end
            end
        end
    endtask

    task automatic test_mult_random(input int count);
        for (int i = 0; i < count; i++) begin
            run_single(OP_MULT, 1'($urandom), $urandom, $urandom);
        end
    endtask

    // back-to-back issues keep two operations in flight.
    task automatic test_accumulate_chain(input int length);
        md_op_e               code;
        logic                 uns;
        md_word_t             a;
        md_word_t             b;
        logic [2*md_xlen-1:0] expect_q [$];
        for (int i = 0; i <= length; i++) begin
            @(negedge clk);
            if (expect_q.size() > 1) begin
                model_hilo = expect_q.pop_front();
                check_flag("done", 1'b1, done);
                check_word("hi", model_hilo[2*md_xlen-1:md_xlen], hi);
                check_word("lo", model_hilo[md_xlen-1:0], lo);
            end
            code = (i == 0) ? OP_MULT : (($urandom & 1) ? OP_MADD : OP_MSUB);
            uns  = 1'($urandom);
            a    = $urandom;
            b    = $urandom;
            drive_request(code, uns, a, b);
            model_hilo = (expect_q.size() > 0) ? expect_q[$] : model_hilo;
            model_apply(code, uns, a, b);
            expect_q.push_back(model_hilo);
        end
        @(negedge clk);
        idle_inputs();
        while (expect_q.size() > 0) begin
            model_hilo = expect_q.pop_front();
            if (expect_q.size() == 0) begin
                @(negedge clk);
            end
            check_flag("done", 1'b1, done);
            check_word("hi", model_hilo[2*md_xlen-1:md_xlen], hi);
            check_word("lo", model_hilo[md_xlen-1:0], lo);
        end
        @(negedge clk);
        check_flag("done", 1'b0, done);
    endtask

    task automatic test_div_corners();
        md_word_t dividends [8] = '{32'd7, -32'sd7, 32'd7, -32'sd7,
                                    32'h8000_0000, 32'h8000_0000, 32'd5, 32'hffff_ffff};
        md_word_t divisors  [8] = '{32'd2, 32'd2, -32'sd2, -32'sd2,
                                    32'hffff_ffff, 32'd1, 32'd7, 32'hffff_ffff};
        for (int u = 0; u < 2; u++) begin
            foreach (dividends[i]) begin
                run_single(OP_DIV, u[0], dividends[i], divisors[i]);
            end
        end
    endtask

    task automatic test_div_random(input int count);
        md_word_t b;
        for (int i = 0; i < count; i++) begin
            b = ($urandom & 1) ? md_word_t'($urandom) : md_word_t'($urandom % 256 + 1);
            run_single(OP_DIV, 1'($urandom), $urandom, b);
        end
    endtask

    task automatic test_div_by_zero();
        md_word_t dividends [4] = '{32'd12345, -32'sd12345, 32'd0, 32'h8000_0000};
        for (int u = 0; u < 2; u++) begin
            foreach (dividends[i]) begin
                run_single(OP_DIV, u[0], dividends[i], '0);
            end
        end
    endtask

    task automatic test_busy_window();
        md_word_t a;
        md_word_t b;
        a = $urandom;
        b = $urandom % 1000 + 1;
        check_flag("busy", 1'b0, busy);
        @(negedge clk);
        drive_request(OP_DIV, 1'b0, a, b);
        @(posedge clk);
        model_apply(OP_DIV, 1'b0, a, b);
        @(negedge clk);
        idle_inputs();
        @(negedge clk);
        check_flag("busy", 1'b1, busy);
        // multiplies offered while the divider runs are dropped.
        for (int i = 0; i < 6; i++) begin
            drive_request(OP_MULT, 1'b1, $urandom, $urandom);
            @(negedge clk);
            check_flag("done", 1'b0, done);
        end
        idle_inputs();
        wait_done(div_latency, 8);
        check_flag("busy", 1'b0, busy);
        check_result();
    endtask

    initial begin
        void'($urandom(32'h077d6ceb));
        rst_n      = 1'b0;
        model_hilo = '0;
        idle_inputs();
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        check_flag("busy", 1'b0, busy);
        check_flag("done", 1'b0, done);
        check_word("hi", '0, hi);
        check_word("lo", '0, lo);

        test_mult_corners();
        test_mult_random(40);
        repeat (3) test_accumulate_chain(10);
        test_div_corners();
        test_div_random(40);
        test_div_by_zero();
        test_busy_window();

        @(negedge clk);
        $display("Run complete: %0d value mismatches, %0d missing done pulses",
                 mismatch_count, missing_count);
        if (mismatch_count == 0 && missing_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
rtl/muldiv_pkg.sv
rtl/muldiv_issue.sv
rtl/radix2_divider.sv
rtl/muldiv_core.sv
rtl/hilo_file.sv
rtl/muldiv_unit.sv
verification/muldiv_unit_tb.sv
